// File: fb_pkg.sv
package fb_pkg;

	// Reduced test raster, counted in pixel clocks and lines
	localparam int H_ACTIVE = 8;
	localparam int H_FRONT  = 2;
	localparam int H_SYNC   = 2;
	localparam int H_BACK   = 2;
	localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

	localparam int V_ACTIVE = 4;
	localparam int V_FRONT  = 1;
	localparam int V_SYNC   = 1;
	localparam int V_BACK   = 1;
	localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

	localparam int CNT_W = 12; // x and y counter width

	// Memory side
	localparam int BEAT_BYTES  = 8;
	localparam int FRAME_BEATS = (H_ACTIVE * V_ACTIVE) / 2; // Two pixels per beat
	localparam int BURST_LEN   = 4;
	localparam int MEM_CREDITS = 4;
	localparam int ADDR_W      = 32;

	// Line FIFO
	localparam int FIFO_DEPTH = 16;
	localparam int FIFO_CNT_W = 5;

	// APB register map
	localparam logic [3:0] REG_CTRL   = 4'h0;
	localparam logic [3:0] REG_BASE   = 4'h4;
	localparam logic [3:0] REG_BORDER = 4'h8;
	localparam logic [3:0] REG_STATUS = 4'hC;

	// Memory pixel layout, red in the top byte
	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
		logic [7:0] pad;
	} pixel_t;

	// Screen colour without the pad byte
	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgb_t;

	// One memory word, either raw or as two pixels
	// pix[0] is the low half and goes out first
	typedef union packed {
		logic [63:0] raw;
		pixel_t [1:0] pix;
	} beat_u;

endpackage

// File: fb_sync_gen.sv
`timescale 1ns/1ps

module fb_sync_gen (
	input  logic                     fbclk,
	input  logic                     fbclk_rst_b,
	input  logic                     run,
	output logic [fb_pkg::CNT_W-1:0] x,
	output logic [fb_pkg::CNT_W-1:0] y,
	output logic                     hs,
	output logic                     vs,
	output logic                     active,
	output logic                     frame_pulse
);

	import fb_pkg::*;

	logic line_end;
	logic frame_end;

	assign line_end  = (x == CNT_W'(H_TOTAL - 1));
	assign frame_end = (y == CNT_W'(V_TOTAL - 1));

	// Counters sit at the origin until the first data has arrived
	always_ff @(posedge fbclk or negedge fbclk_rst_b) begin
		if (!fbclk_rst_b) begin
			x <= '0;
			y <= '0;
		end else if (!run) begin
			x <= '0;
			y <= '0;
		end else if (line_end) begin
			x <= '0;
			if (frame_end)
				y <= '0;
			else
				y <= y + 1'b1;
		end else begin
			x <= x + 1'b1;
		end
	end

	// Sync pulses inside the blanking intervals
	assign hs = run && (x >= CNT_W'(H_ACTIVE + H_FRONT)) &&
		(x < CNT_W'(H_ACTIVE + H_FRONT + H_SYNC));
	assign vs = run && (y >= CNT_W'(V_ACTIVE + V_FRONT)) &&
		(y < CNT_W'(V_ACTIVE + V_FRONT + V_SYNC));

	assign active      = run && (x < CNT_W'(H_ACTIVE)) && (y < CNT_W'(V_ACTIVE));
	assign frame_pulse = run && (x == '0) && (y == '0); // First pixel of a frame

	a_hs_in_blank: assert property (@(posedge fbclk) disable iff (!fbclk_rst_b)
		!(hs && active));

endmodule

// File: fb_line_fifo.sv
`timescale 1ns/1ps

module fb_line_fifo (
	input  logic                          fbclk,
	input  logic                          fbclk_rst_b,
	input  logic                          wr_en,
	input  fb_pkg::beat_u                 wr_data,
	input  logic                          pop,
	output fb_pkg::beat_u                 rd_data,
	output logic                          empty,
	output logic [fb_pkg::FIFO_CNT_W-1:0] count
);

	import fb_pkg::*;

	beat_u mem [FIFO_DEPTH];

	logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
	logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
	logic                          full;

	assign empty = (count == '0);
	assign full  = (count == FIFO_CNT_W'(FIFO_DEPTH));

	// Storage
	always_ff @(posedge fbclk) begin
		if (wr_en)
			mem[wr_ptr] <= wr_data;
	end

	assign rd_data = mem[rd_ptr]; // Show-ahead, valid while not empty

	always_ff @(posedge fbclk or negedge fbclk_rst_b) begin
		if (!fbclk_rst_b) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1; // Wraps at the depth
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({wr_en, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// The DMA space check and the pixel stage keep these from happening
	a_no_pop_empty: assert property (@(posedge fbclk) disable iff (!fbclk_rst_b)
		pop |-> !empty);
	a_no_write_full: assert property (@(posedge fbclk) disable iff (!fbclk_rst_b)
		wr_en |-> !full);

endmodule

// File: fb_dma_read.sv
`timescale 1ns/1ps

module fb_dma_read (
	input  logic                          fbclk,
	input  logic                          fbclk_rst_b,
	input  logic                          enable,
	input  logic [fb_pkg::ADDR_W-1:0]     base_addr,
	input  logic [fb_pkg::FIFO_CNT_W-1:0] fifo_count,
	output logic                          mem_req_valid,
	output logic [fb_pkg::ADDR_W-1:0]     mem_req_addr,
	output logic [7:0]                    mem_req_len,
	input  logic                          mem_credit,
	input  logic                          mem_rsp_valid,
	input  fb_pkg::beat_u                 mem_rsp_data,
	output logic                          wr_en,
	output fb_pkg::beat_u                 wr_data
);

	import fb_pkg::*;

	logic [$clog2(MEM_CREDITS+1)-1:0] credits;
	logic [FIFO_CNT_W-1:0]            outstanding; // Beats requested, not yet returned
	logic [$clog2(FRAME_BEATS)-1:0]   beat_idx;    // Beat offset in the frame
	logic                             run_en;
	logic [ADDR_W-1:0]                run_base;
	logic [FIFO_CNT_W:0]              need;
	logic                             issue;

	// Worst case fill once this burst and everything in flight has landed
	assign need = {1'b0, fifo_count} + {1'b0, outstanding} +
		(FIFO_CNT_W+1)'(wr_en) + (FIFO_CNT_W+1)'(BURST_LEN);

	assign issue = run_en && (credits != '0) &&
		(need <= (FIFO_CNT_W+1)'(FIFO_DEPTH));

	assign mem_req_len = 8'(BURST_LEN);

	always_ff @(posedge fbclk or negedge fbclk_rst_b) begin
		if (!fbclk_rst_b) begin
			credits       <= ($clog2(MEM_CREDITS+1))'(MEM_CREDITS);
			outstanding   <= '0;
			beat_idx      <= '0;
			run_en        <= 1'b0;
			run_base      <= '0;
			mem_req_valid <= 1'b0;
			wr_en         <= 1'b0;
		end else begin
			mem_req_valid <= issue;
			wr_en         <= mem_rsp_valid;

			case ({issue, mem_credit})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits;
			endcase

			outstanding <= outstanding + (issue ? FIFO_CNT_W'(BURST_LEN) : '0) -
				FIFO_CNT_W'(mem_rsp_valid);

			if (issue) begin
				if (beat_idx == ($clog2(FRAME_BEATS))'(FRAME_BEATS - BURST_LEN))
					beat_idx <= '0; // Back to the base
				else
					beat_idx <= beat_idx + ($clog2(FRAME_BEATS))'(BURST_LEN);
			end

			// New base and enable only take effect between frames
			if (beat_idx == '0 && !issue) begin
				run_en   <= enable;
				run_base <= base_addr;
			end
		end
	end

	always_ff @(posedge fbclk) begin
		if (issue)
			mem_req_addr <= run_base + ADDR_W'(beat_idx) * ADDR_W'(BEAT_BYTES);
		wr_data <= mem_rsp_data;
	end

	a_credit_bound: assert property (@(posedge fbclk) disable iff (!fbclk_rst_b)
		credits <= ($clog2(MEM_CREDITS+1))'(MEM_CREDITS));

endmodule

// File: fb_regs.sv
`timescale 1ns/1ps

module fb_regs (
	input  logic                      fbclk,
	input  logic                      fbclk_rst_b,
	input  logic                      psel,
	input  logic                      penable,
	input  logic                      pwrite,
	input  logic [3:0]                paddr,
	input  logic [31:0]               pwdata,
	output logic [31:0]               prdata,
	output logic                      pready,
	output logic                      pslverr,
	input  logic                      underflow_pulse,
	input  logic                      frame_pulse,
	output logic                      enable,
	output logic [fb_pkg::ADDR_W-1:0] base_addr,
	output fb_pkg::rgb_t              border
);

	import fb_pkg::*;

	logic       access;
	logic       mapped;
	logic       underflow; // Sticky, write 1 to clear
	logic [7:0] frame_cnt;

	assign access  = psel && penable;
	assign pready  = 1'b1; // No wait states
	assign pslverr = access && !mapped;

	always_comb begin
		mapped = 1'b1;
		prdata = '0;
		case (paddr)
			REG_CTRL:   prdata = {31'b0, enable};
			REG_BASE:   prdata = base_addr;
			REG_BORDER: prdata = {8'b0, border};
			REG_STATUS: prdata = {16'b0, frame_cnt, 7'b0, underflow};
			default:    mapped = 1'b0;
		endcase
	end

	always_ff @(posedge fbclk or negedge fbclk_rst_b) begin
		if (!fbclk_rst_b) begin
			enable    <= 1'b0;
			base_addr <= '0;
			border    <= '0;
			underflow <= 1'b0;
			frame_cnt <= '0;
		end else begin
			if (access && pwrite) begin
				case (paddr)
					REG_CTRL:   enable    <= pwdata[0];
					REG_BASE:   base_addr <= pwdata;
					REG_BORDER: border    <= pwdata[23:0];
					default:    ;
				endcase
			end
			if (underflow_pulse)
				underflow <= 1'b1; // Set wins over a clear in the same cycle
			else if (access && pwrite && paddr == REG_STATUS && pwdata[0])
				underflow <= 1'b0;
			if (frame_pulse)
				frame_cnt <= frame_cnt + 1'b1; // Wraps at 8 bits
		end
	end

	a_apb_setup: assert property (@(posedge fbclk) disable iff (!fbclk_rst_b)
		penable |-> psel);

endmodule

// File: fb_pixel_out.sv
`timescale 1ns/1ps

module fb_pixel_out (
	input  logic                     fbclk,
	input  logic                     fbclk_rst_b,
	input  logic                     enable,
	input  logic                     fifo_empty,
	input  fb_pkg::beat_u            rd_data,
	input  logic [fb_pkg::CNT_W-1:0] x,
	input  logic                     hs_in,
	input  logic                     vs_in,
	input  logic                     active,
	input  fb_pkg::rgb_t             border,
	output logic                     run,
	output logic                     pop,
	output logic                     underflow_pulse,
	output fb_pkg::rgb_t             pix,
	output logic                     de,
	output logic                     hs,
	output logic                     vs
);

	import fb_pkg::*;

	logic   second;      // Odd x, high half of the word
	logic   starved_q;   // First pixel of this word found no data
	logic   show_border;
	pixel_t half;
	rgb_t   pix_d;

	assign second = x[0];
	assign half   = rd_data.pix[second];

	// Border in blanking and for the rest of a starved word
	assign show_border = !active || fifo_empty || (second && starved_q);

	assign pop = active && second && !fifo_empty && !starved_q; // Word done

	always_comb begin
		if (show_border)
			pix_d = border;
		else
			pix_d = '{red: half.red, green: half.green, blue: half.blue};
	end

	always_ff @(posedge fbclk or negedge fbclk_rst_b) begin
		if (!fbclk_rst_b) begin
			run             <= 1'b0;
			starved_q       <= 1'b0;
			underflow_pulse <= 1'b0;
			de              <= 1'b0;
			hs              <= 1'b0;
			vs              <= 1'b0;
		end else begin
			run             <= run || (enable && !fifo_empty); // Latches on
			starved_q       <= active && !second && fifo_empty;
			underflow_pulse <= active && fifo_empty && !(second && starved_q);
			de              <= active;
			hs              <= hs_in;
			vs              <= vs_in;
		end
	end

	always_ff @(posedge fbclk) begin
		pix <= pix_d;
	end

endmodule

// File: framebuffer.sv
`timescale 1ns/1ps

module framebuffer (
	input  logic                      fbclk,
	input  logic                      fbclk_rst_b,
	// APB
	input  logic                      psel,
	input  logic                      penable,
	input  logic                      pwrite,
	input  logic [3:0]                paddr,
	input  logic [31:0]               pwdata,
	output logic [31:0]               prdata,
	output logic                      pready,
	output logic                      pslverr,
	// Memory read port
	output logic                      mem_req_valid,
	output logic [fb_pkg::ADDR_W-1:0] mem_req_addr,
	output logic [7:0]                mem_req_len,
	input  logic                      mem_credit,
	input  logic                      mem_rsp_valid,
	input  fb_pkg::beat_u             mem_rsp_data,
	// Pixel output
	output fb_pkg::rgb_t              pix,
	output logic                      de,
	output logic                      hs,
	output logic                      vs
);

	import fb_pkg::*;

	logic                  enable;
	logic [ADDR_W-1:0]     base_addr;
	rgb_t                  border;
	logic                  wr_en;
	beat_u                 wr_data;
	beat_u                 rd_data;
	logic                  pop;
	logic                  fifo_empty;
	logic [FIFO_CNT_W-1:0] fifo_count;
	logic                  run;
	logic [CNT_W-1:0]      x;
	logic                  sg_hs;
	logic                  sg_vs;
	logic                  active;
	logic                  frame_pulse;
	logic                  underflow_pulse;

	fb_regs regs_i (.fbclk, .fbclk_rst_b, .psel, .penable, .pwrite, .paddr, .pwdata,
		.prdata, .pready, .pslverr, .underflow_pulse, .frame_pulse, .enable,
		.base_addr, .border);

	fb_dma_read dma_i (.fbclk, .fbclk_rst_b, .enable, .base_addr,
		.fifo_count, .mem_req_valid, .mem_req_addr, .mem_req_len, .mem_credit,
		.mem_rsp_valid, .mem_rsp_data, .wr_en, .wr_data);

	fb_line_fifo fifo_i (.fbclk, .fbclk_rst_b, .wr_en, .wr_data, .pop, .rd_data,
		.empty(fifo_empty), .count(fifo_count));

	// Line count is decoded inside the sync generator only
	fb_sync_gen sync_i (.fbclk, .fbclk_rst_b, .run, .x, .y(), .hs(sg_hs), .vs(sg_vs),
		.active, .frame_pulse);

	fb_pixel_out pix_i (.fbclk, .fbclk_rst_b, .enable, .fifo_empty, .rd_data, .x,
		.hs_in(sg_hs), .vs_in(sg_vs), .active, .border, .run, .pop,
		.underflow_pulse, .pix, .de, .hs, .vs);

endmodule

// File: tb_framebuffer.sv
`timescale 1ns/1ps

module tb_framebuffer;

	import fb_pkg::*;

	localparam int NUM_TESTS = 4;

	// Test table, one column per entry
	string       t_name   [NUM_TESTS] = '{"pixels_base0", "frame_wrap", "late_memory", "underflow"};
	logic [31:0] t_base   [NUM_TESTS] = '{32'h0, 32'h1000, 32'h380, 32'h2000};
	logic [23:0] t_border [NUM_TESTS] = '{24'h102030, 24'h00ff00, 24'h5a0c33, 24'h0000ff};
	int          t_lat    [NUM_TESTS] = '{2, 2, 9, 200};
	int          t_frames [NUM_TESTS] = '{1, 3, 2, 2};
	bit          t_uf     [NUM_TESTS] = '{1'b0, 1'b0, 1'b0, 1'b1};

	logic fbclk;
	logic fbclk_rst_b;
	logic psel, penable, pwrite;
	logic [3:0] paddr;
	logic [31:0] pwdata, prdata;
	logic pready, pslverr;
	logic mem_req_valid;
	logic [ADDR_W-1:0] mem_req_addr;
	logic [7:0] mem_req_len;
	logic mem_credit = 1'b0;
	logic mem_rsp_valid = 1'b0;
	beat_u mem_rsp_data = '0;
	rgb_t pix;
	logic de, hs, vs;

	string cur_name = "init";
	int errors = 0;
	int cyc = 0;
	int cyc_limit = 0;
	int mem_latency = 2;
	logic [31:0] cur_base = '0;
	logic [31:0] req_next = '0; // Next request address the DMA should issue
	rgb_t cur_border = '0;
	bit check_pix = 1'b0;
	bit mon_on = 1'b0;
	int de_cnt, hs_cnt, vs_cnt, de_target;
	logic hs_prev = 1'b0;
	logic vs_prev = 1'b0;
	logic [31:0] req_addr_q[$];
	int req_due_q[$];
	logic [31:0] burst_addr;
	int beats_left = 0;

	framebuffer dut_i (.fbclk, .fbclk_rst_b, .psel, .penable, .pwrite, .paddr, .pwdata,
		.prdata, .pready, .pslverr, .mem_req_valid, .mem_req_addr, .mem_req_len,
		.mem_credit, .mem_rsp_valid, .mem_rsp_data, .pix, .de, .hs, .vs);

	initial begin
		fbclk = 1'b0;
		forever #5 fbclk = ~fbclk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] v;
		v = s;
		v = v ^ (v << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	// Memory contents, both halves depend on the full address
	function automatic logic [63:0] mem_word(input logic [31:0] addr);
		logic [31:0] lo;
		lo = xorshift32(addr ^ 32'h2d3);
		return {xorshift32(lo ^ addr), lo};
	endfunction

	// Pixel p of the frame, even p in the low half, red on top
	function automatic rgb_t expected_pixel(input logic [31:0] base, input int p);
		logic [63:0] w;
		w = mem_word(base + 32'((p / 2) * BEAT_BYTES));
		return (p % 2) ? w[63:40] : w[31:8];
	endfunction

	task automatic check_rgb(input string what, input rgb_t exp, input rgb_t act);
		if (act !== exp) begin
			errors++;
			$display("Fail %s %s: expected %h, actual %h", cur_name, what, exp, act);
		end
	endtask

	task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			errors++;
			$display("Fail %s %s: expected %h, actual %h", cur_name, what, exp, act);
		end
	endtask

	task automatic check_bit(input string what, input logic exp, input logic act);
		if (act !== exp) begin
			errors++;
			$display("Fail %s %s: expected %b, actual %b", cur_name, what, exp, act);
		end
	endtask

	task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
		@(posedge fbclk);
		#1 {psel, penable, pwrite, paddr, pwdata} = {3'b101, addr, data};
		@(posedge fbclk);
		#1 penable = 1'b1; // Access phase, zero wait states
		@(negedge fbclk);
		check_bit("pready on write", 1'b1, pready);
		@(posedge fbclk);
		#1 {psel, penable, pwrite} = 3'b000;
	endtask

	task automatic read_reg(input logic [3:0] addr, output logic [31:0] data, output logic err);
		@(posedge fbclk);
		#1 {psel, penable, pwrite, paddr} = {3'b100, addr};
		@(posedge fbclk);
		#1 penable = 1'b1;
		@(negedge fbclk);
		data = prdata;
		err  = pslverr;
		@(posedge fbclk);
		#1 {psel, penable} = 2'b00;
	endtask

	// Memory model, answers bursts in request order
	always @(posedge fbclk) begin
		#1;
		mem_rsp_valid = 1'b0;
		mem_credit    = 1'b0;
		if (!fbclk_rst_b) begin
			req_addr_q.delete();
			req_due_q.delete();
			beats_left = 0;
		end else begin
			if (mem_req_valid) begin
				check_word("request address", req_next, mem_req_addr);
				check_word("request length", BURST_LEN, 32'(mem_req_len));
				req_next = cur_base + ((req_next - cur_base + BURST_LEN * BEAT_BYTES) %
					(FRAME_BEATS * BEAT_BYTES)); // Wrap to the base
				req_addr_q.push_back(mem_req_addr);
				req_due_q.push_back(cyc + mem_latency);
			end
			if (beats_left == 0 && req_addr_q.size() > 0 && req_due_q[0] <= cyc) begin
				burst_addr = req_addr_q.pop_front();
				void'(req_due_q.pop_front());
				beats_left = BURST_LEN;
			end
			if (beats_left > 0) begin
				mem_rsp_valid    = 1'b1;
				mem_rsp_data.raw = mem_word(burst_addr);
				burst_addr       = burst_addr + BEAT_BYTES;
				beats_left--;
				mem_credit       = (beats_left == 0); // Credit back on the last beat
			end
		end
	end

	// Scoreboard on the pixel outputs
	always @(negedge fbclk) begin
		if (mon_on && de_cnt < de_target) begin
			if (hs && !hs_prev)
				hs_cnt++;
			if (vs && !vs_prev)
				vs_cnt++;
			if (de) begin
				if (check_pix)
					check_rgb($sformatf("pixel %0d", de_cnt % (H_ACTIVE * V_ACTIVE)),
						expected_pixel(cur_base, de_cnt % (H_ACTIVE * V_ACTIVE)), pix);
				de_cnt++;
			end else begin
				check_rgb("border", cur_border, pix);
			end
		end
		hs_prev = hs;
		vs_prev = vs;
	end

	always @(posedge fbclk) begin
		cyc = cyc + 1;
		if (cyc > cyc_limit) begin
			$display("Timeout: test %s did not finish within %0d cycles", cur_name, cyc_limit);
			$display("Simulation failed");
			$finish;
		end
	end

	task automatic reset_dut();
		mon_on = 1'b0;
		@(posedge fbclk);
		#1 fbclk_rst_b = 1'b0;
		repeat (8) @(posedge fbclk);
		#1 fbclk_rst_b = 1'b1;
		check_bit("mem_req_valid after reset", 1'b0, mem_req_valid);
		check_bit("de after reset", 1'b0, de);
		check_bit("hs after reset", 1'b0, hs);
		check_bit("vs after reset", 1'b0, vs);
		check_bit("pslverr after reset", 1'b0, pslverr);
	endtask

	task automatic run_test(input int i);
		logic [31:0] rd;
		logic        err;
		int          err_start;
		err_start   = errors;
		cur_name    = t_name[i];
		cur_border  = t_border[i];
		check_pix   = !t_uf[i];
		reset_dut();
		mem_latency = t_lat[i];
		cur_base    = t_base[i];
		req_next    = t_base[i];
		read_reg(REG_CTRL, rd, err);
		check_word("CTRL after reset", 32'h0, rd);
		read_reg(REG_STATUS, rd, err);
		check_word("STATUS after reset", 32'h0, rd);
		write_reg(REG_BASE, t_base[i]);
		write_reg(REG_BORDER, {8'h0, t_border[i]});
		read_reg(REG_BASE, rd, err);
		check_word("BASE readback", t_base[i], rd);
		check_bit("pslverr on BASE", 1'b0, err);
		read_reg(REG_BORDER, rd, err);
		check_word("BORDER readback", {8'h0, t_border[i]}, rd);
		read_reg(4'h2, rd, err);
		check_bit("pslverr on unmapped offset", 1'b1, err);
		de_target = t_frames[i] * H_ACTIVE * V_ACTIVE;
		{de_cnt, hs_cnt, vs_cnt} = '0;
		mon_on = 1'b1;
		write_reg(REG_CTRL, 32'h1);
		while (de_cnt < de_target)
			@(negedge fbclk);
		read_reg(REG_STATUS, rd, err); // Before the next frame starts
		check_word("frame count", t_frames[i], 32'(rd[15:8]));
		check_bit("underflow flag", t_uf[i], rd[0]);
		check_word("hs pulses", V_TOTAL * (t_frames[i] - 1) + V_ACTIVE - 1, hs_cnt);
		check_word("vs pulses", t_frames[i] - 1, vs_cnt);
		if (t_uf[i]) begin
			// Clear inside vertical blanking so no new underflow races it
			do
				@(negedge fbclk);
			while (!vs);
			write_reg(REG_STATUS, 32'h1);
			read_reg(REG_STATUS, rd, err);
			check_bit("underflow cleared", 1'b0, rd[0]);
		end
		$display("Test %s: %s, %0d errors", cur_name,
			(errors == err_start) ? "ok" : "not ok", errors - err_start);
	endtask

	initial begin
		int bad_tests;
		int err_before;
		bad_tests   = 0;
		fbclk_rst_b = 1'b0;
		{psel, penable, pwrite, paddr, pwdata} = '0;
		cyc_limit = 500;
		for (int i = 0; i < NUM_TESTS; i++)
			cyc_limit += t_frames[i] * H_TOTAL * V_TOTAL + t_lat[i] + 150;
		for (int i = 0; i < NUM_TESTS; i++) begin
			err_before = errors;
			run_test(i);
			if (errors != err_before)
				bad_tests++;
		end
		$display("%0d tests, %0d ok, %0d not ok, %0d check errors", NUM_TESTS,
			NUM_TESTS - bad_tests, bad_tests, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// File: framebuffer.f
fb_pkg.sv
fb_sync_gen.sv
fb_line_fifo.sv
fb_dma_read.sv
fb_regs.sv
fb_pixel_out.sv
framebuffer.sv
tb_framebuffer.sv
